// File: verilog/vga_timing_pkg.sv
package vga_timing_pkg;

    // 640x480 at 60 Hz, counts in pixel clocks and lines
    localparam int H_DISPLAY_DEF = 640;
    localparam int H_FRONT_DEF   = 16;
    localparam int H_SYNC_DEF    = 96;
    localparam int H_BACK_DEF    = 48;

    localparam int V_DISPLAY_DEF = 480;
    localparam int V_FRONT_DEF   = 10;
    localparam int V_SYNC_DEF    = 2;
    localparam int V_BACK_DEF    = 33;

    // Pixel counters cover the full 800x525 period
    localparam int COORD_W = 10;

    // Cell indices, wide enough for the porches at small cell sizes
    localparam int CELL_W = 6;

endpackage

// File: verilog/game_pkg.sv
package game_pkg;

    typedef enum logic [1:0] {
        BLACK,
        WHITE,
        GREEN,
        RED
    } pixel_color_e;

    typedef enum logic [2:0] {
        NONE,
        UP,
        DOWN,
        LEFT,
        RIGHT
    } move_dir_e;

    // {r, g, b}, 3 bits per channel
    function automatic logic [8:0] rgb_of(pixel_color_e c);
        case (c)
            WHITE:   return 9'b111_111_111;
            GREEN:   return 9'b000_111_000;
            RED:     return 9'b111_000_000;
            default: return 9'b000_000_000;
        endcase
    endfunction

    // True when col lies within the car starting at car, counted with wrap
    function automatic logic car_hit(logic [vga_timing_pkg::CELL_W-1:0] col,
                                     logic [vga_timing_pkg::CELL_W-1:0] car,
                                     int cols, int cells);
        int off;
        off = (col >= car) ? int'(col) - int'(car) : int'(col) + cols - int'(car);
        return off < cells;
    endfunction

    localparam int NUM_LANES         = 4;
    localparam int CELL_SIZE_DEF     = 32;
    localparam int LANE_ROW0_DEF     = 9;   // Lanes on rows 9..12 of 15
    localparam int CAR_CELLS_DEF     = 2;
    localparam int PLAYER_FRAMES_DEF = 8;
    localparam int CAR_FRAMES_DEF    = 10;
    localparam int TILE_MARGIN_DEF   = 3;

endpackage

// File: verilog/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_DISPLAY = vga_timing_pkg::H_DISPLAY_DEF,
    parameter int H_FRONT   = vga_timing_pkg::H_FRONT_DEF,
    parameter int H_SYNC    = vga_timing_pkg::H_SYNC_DEF,
    parameter int H_BACK    = vga_timing_pkg::H_BACK_DEF,
    parameter int V_DISPLAY = vga_timing_pkg::V_DISPLAY_DEF,
    parameter int V_FRONT   = vga_timing_pkg::V_FRONT_DEF,
    parameter int V_SYNC    = vga_timing_pkg::V_SYNC_DEF,
    parameter int V_BACK    = vga_timing_pkg::V_BACK_DEF,
    parameter int CELL_SIZE = game_pkg::CELL_SIZE_DEF
) (
    input  logic                               CLK,
    input  logic                               arst_n,
    output logic                               h_sync_raw,
    output logic                               v_sync_raw,
    output logic                               active,
    output logic                               frame_start,
    output logic [vga_timing_pkg::CELL_W-1:0]  cell_col,
    output logic [vga_timing_pkg::CELL_W-1:0]  cell_row,
    output logic [vga_timing_pkg::COORD_W-1:0] in_col,
    output logic [vga_timing_pkg::COORD_W-1:0] in_row
);
    localparam int CW       = vga_timing_pkg::COORD_W;
    localparam int H_TOTAL  = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_DISPLAY + H_FRONT;
    localparam int VS_START = V_DISPLAY + V_FRONT;

    logic [CW-1:0] h_cnt;
    logic [CW-1:0] v_cnt;
    logic          line_end;
    logic          frame_end;

    assign line_end  = h_cnt == CW'(H_TOTAL - 1);
    assign frame_end = line_end && v_cnt == CW'(V_TOTAL - 1);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Cell counters step with the pixel counters, no divider needed
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cell_col <= '0;
            in_col   <= '0;
        end else if (line_end) begin
            cell_col <= '0;
            in_col   <= '0;
        end else if (h_cnt < CW'(H_DISPLAY)) begin
            if (in_col == CW'(CELL_SIZE - 1)) begin
                in_col   <= '0;
                cell_col <= cell_col + 1'b1;
            end else begin
                in_col <= in_col + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cell_row <= '0;
            in_row   <= '0;
        end else if (frame_end) begin
            cell_row <= '0;
            in_row   <= '0;
        end else if (line_end && v_cnt < CW'(V_DISPLAY)) begin
            if (in_row == CW'(CELL_SIZE - 1)) begin
                in_row   <= '0;
                cell_row <= cell_row + 1'b1;
            end else begin
                in_row <= in_row + 1'b1;
            end
        end
    end

    assign h_sync_raw  = !(h_cnt >= CW'(HS_START) && h_cnt < CW'(HS_START + H_SYNC));
    assign v_sync_raw  = !(v_cnt >= CW'(VS_START) && v_cnt < CW'(VS_START + V_SYNC));
    assign active      = h_cnt < CW'(H_DISPLAY) && v_cnt < CW'(V_DISPLAY);
    assign frame_start = h_cnt == '0 && v_cnt == '0;

    a_cnt_range: assert property (@(posedge CLK) disable iff (!arst_n)
        h_cnt < CW'(H_TOTAL) && v_cnt < CW'(V_TOTAL));

endmodule

// File: verilog/player_ctrl.sv
`timescale 1ns/1ps

module player_ctrl #(
    parameter int H_DISPLAY     = vga_timing_pkg::H_DISPLAY_DEF,
    parameter int V_DISPLAY     = vga_timing_pkg::V_DISPLAY_DEF,
    parameter int CELL_SIZE     = game_pkg::CELL_SIZE_DEF,
    parameter int LANE_ROW0     = game_pkg::LANE_ROW0_DEF,
    parameter int CAR_CELLS     = game_pkg::CAR_CELLS_DEF,
    parameter int PLAYER_FRAMES = game_pkg::PLAYER_FRAMES_DEF
) (
    input  logic                              CLK,
    input  logic                              arst_n,
    input  logic                              btn_up,
    input  logic                              btn_down,
    input  logic                              btn_left,
    input  logic                              btn_right,
    input  logic                              frame_start,
    input  logic [vga_timing_pkg::CELL_W-1:0] car_col [game_pkg::NUM_LANES],
    output logic [vga_timing_pkg::CELL_W-1:0] player_col,
    output logic [vga_timing_pkg::CELL_W-1:0] player_row
);
    localparam int CW        = vga_timing_pkg::CELL_W;
    localparam int COLS      = H_DISPLAY / CELL_SIZE;
    localparam int ROWS      = V_DISPLAY / CELL_SIZE;
    localparam int CD_W      = $clog2(PLAYER_FRAMES + 2);
    localparam int START_COL = COLS / 2;
    localparam int START_ROW = ROWS - 1;

    logic [3:0]          btn_meta;
    logic [3:0]          btn_sync;  // {up, down, left, right}
    logic [CD_W-1:0]     cooldown;
    game_pkg::move_dir_e dir;
    logic                in_bounds;
    logic                hit;
    logic                do_move;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= {btn_up, btn_down, btn_left, btn_right};
            btn_sync <= btn_meta;
        end
    end

    // Fixed priority, the losing buttons are ignored
    always_comb begin
        dir = game_pkg::NONE;
        if (btn_sync[3])      dir = game_pkg::UP;
        else if (btn_sync[2]) dir = game_pkg::DOWN;
        else if (btn_sync[1]) dir = game_pkg::LEFT;
        else if (btn_sync[0]) dir = game_pkg::RIGHT;
    end

    always_comb begin
        case (dir)
            game_pkg::UP:    in_bounds = player_row != '0;
            game_pkg::DOWN:  in_bounds = player_row != CW'(ROWS - 1);
            game_pkg::LEFT:  in_bounds = player_col != '0;
            game_pkg::RIGHT: in_bounds = player_col != CW'(COLS - 1);
            default:         in_bounds = 1'b0;
        endcase
    end

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < game_pkg::NUM_LANES; i++) begin
            if (player_row == CW'(LANE_ROW0 + i) &&
                game_pkg::car_hit(player_col, car_col[i], COLS, CAR_CELLS))
                hit = 1'b1;
        end
    end

    assign do_move = frame_start && cooldown == '0 && in_bounds && !hit;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            player_col <= CW'(START_COL);
            player_row <= CW'(START_ROW);
            cooldown   <= '0;
        end else begin
            if (hit) begin  // Back to start, wins over a move
                player_col <= CW'(START_COL);
                player_row <= CW'(START_ROW);
            end else if (do_move) begin
                case (dir)
                    game_pkg::UP:    player_row <= player_row - 1'b1;
                    game_pkg::DOWN:  player_row <= player_row + 1'b1;
                    game_pkg::LEFT:  player_col <= player_col - 1'b1;
                    game_pkg::RIGHT: player_col <= player_col + 1'b1;
                    default:         ;
                endcase
            end
            if (do_move)
                cooldown <= CD_W'(PLAYER_FRAMES);
            else if (frame_start && cooldown != '0)
                cooldown <= cooldown - 1'b1;
        end
    end

    a_in_grid: assert property (@(posedge CLK) disable iff (!arst_n)
        player_col < CW'(COLS) && player_row < CW'(ROWS));

    a_move_at_frame: assert property (@(posedge CLK) disable iff (!arst_n)
        (!frame_start && !hit) |=> $stable({player_col, player_row}));

endmodule

// File: verilog/traffic_lanes.sv
`timescale 1ns/1ps

module traffic_lanes #(
    parameter int H_DISPLAY  = vga_timing_pkg::H_DISPLAY_DEF,
    parameter int CELL_SIZE  = game_pkg::CELL_SIZE_DEF,
    parameter int CAR_FRAMES = game_pkg::CAR_FRAMES_DEF
) (
    input  logic                              CLK,
    input  logic                              arst_n,
    input  logic                              frame_start,
    output logic [vga_timing_pkg::CELL_W-1:0] car_col [game_pkg::NUM_LANES]
);
    localparam int CW    = vga_timing_pkg::CELL_W;
    localparam int COLS  = H_DISPLAY / CELL_SIZE;
    localparam int CNT_W = $clog2(CAR_FRAMES + game_pkg::NUM_LANES + 1);

    for (genvar i = 0; i < game_pkg::NUM_LANES; i++) begin : g_lane
        // Lane i moves once every CAR_FRAMES + i frames
        localparam int PERIOD = CAR_FRAMES + i;

        logic [CNT_W-1:0] frame_cnt;

        always_ff @(posedge CLK or negedge arst_n) begin
            if (!arst_n) begin
                frame_cnt  <= '0;
                car_col[i] <= '0;
            end else if (frame_start) begin
                if (frame_cnt == CNT_W'(PERIOD - 1)) begin
                    frame_cnt  <= '0;
                    car_col[i] <= (car_col[i] == CW'(COLS - 1)) ? '0 : car_col[i] + 1'b1;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end

        a_col_range: assert property (@(posedge CLK) disable iff (!arst_n)
            car_col[i] < CW'(COLS));
    end

endmodule

// File: verilog/pixel_render.sv
`timescale 1ns/1ps

module pixel_render #(
    parameter int H_DISPLAY   = vga_timing_pkg::H_DISPLAY_DEF,
    parameter int CELL_SIZE   = game_pkg::CELL_SIZE_DEF,
    parameter int LANE_ROW0   = game_pkg::LANE_ROW0_DEF,
    parameter int CAR_CELLS   = game_pkg::CAR_CELLS_DEF,
    parameter int TILE_MARGIN = game_pkg::TILE_MARGIN_DEF
) (
    input  logic                               CLK,
    input  logic                               arst_n,
    input  logic                               h_sync_raw,
    input  logic                               v_sync_raw,
    input  logic                               active,
    input  logic [vga_timing_pkg::CELL_W-1:0]  cell_col,
    input  logic [vga_timing_pkg::CELL_W-1:0]  cell_row,
    input  logic [vga_timing_pkg::COORD_W-1:0] in_col,
    input  logic [vga_timing_pkg::COORD_W-1:0] in_row,
    input  logic [vga_timing_pkg::CELL_W-1:0]  player_col,
    input  logic [vga_timing_pkg::CELL_W-1:0]  player_row,
    input  logic [vga_timing_pkg::CELL_W-1:0]  car_col [game_pkg::NUM_LANES],
    output logic [2:0]                         vga_r,
    output logic [2:0]                         vga_g,
    output logic [2:0]                         vga_b,
    output logic                               vga_hs,
    output logic                               vga_vs
);
    localparam int CW   = vga_timing_pkg::CELL_W;
    localparam int PW   = vga_timing_pkg::COORD_W;
    localparam int COLS = H_DISPLAY / CELL_SIZE;

    game_pkg::pixel_color_e color;
    logic                   on_car;
    logic                   on_lane;
    logic                   on_tile;
    logic [8:0]             rgb;
    logic                   active_q;

    always_comb begin
        on_car = 1'b0;
        for (int i = 0; i < game_pkg::NUM_LANES; i++) begin
            if (cell_row == CW'(LANE_ROW0 + i) &&
                game_pkg::car_hit(cell_col, car_col[i], COLS, CAR_CELLS))
                on_car = 1'b1;
        end
    end

    assign on_lane = cell_row >= CW'(LANE_ROW0) &&
                     cell_row < CW'(LANE_ROW0 + game_pkg::NUM_LANES);
    assign on_tile = in_col >= PW'(TILE_MARGIN) && in_col < PW'(CELL_SIZE - TILE_MARGIN) &&
                     in_row >= PW'(TILE_MARGIN) && in_row < PW'(CELL_SIZE - TILE_MARGIN);

    // Player over cars over road tiles over black
    always_comb begin
        if (!active)
            color = game_pkg::BLACK;
        else if (cell_col == player_col && cell_row == player_row)
            color = game_pkg::GREEN;
        else if (on_car)
            color = game_pkg::RED;
        else if (on_lane && on_tile)
            color = game_pkg::WHITE;
        else
            color = game_pkg::BLACK;
    end

    assign rgb = game_pkg::rgb_of(color);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            {vga_r, vga_g, vga_b} <= '0;
            vga_hs   <= 1'b1;   // Syncs idle high
            vga_vs   <= 1'b1;
            active_q <= 1'b0;
        end else begin
            {vga_r, vga_g, vga_b} <= rgb;
            vga_hs   <= h_sync_raw;
            vga_vs   <= v_sync_raw;
            active_q <= active;
        end
    end

    a_blank: assert property (@(posedge CLK) !active_q |-> {vga_r, vga_g, vga_b} == '0);

endmodule

// File: verilog/frogger_top.sv
`timescale 1ns/1ps

module frogger_top #(
    parameter int H_DISPLAY     = vga_timing_pkg::H_DISPLAY_DEF,
    parameter int H_FRONT       = vga_timing_pkg::H_FRONT_DEF,
    parameter int H_SYNC        = vga_timing_pkg::H_SYNC_DEF,
    parameter int H_BACK        = vga_timing_pkg::H_BACK_DEF,
    parameter int V_DISPLAY     = vga_timing_pkg::V_DISPLAY_DEF,
    parameter int V_FRONT       = vga_timing_pkg::V_FRONT_DEF,
    parameter int V_SYNC        = vga_timing_pkg::V_SYNC_DEF,
    parameter int V_BACK        = vga_timing_pkg::V_BACK_DEF,
    parameter int CELL_SIZE     = game_pkg::CELL_SIZE_DEF,
    parameter int LANE_ROW0     = game_pkg::LANE_ROW0_DEF,
    parameter int CAR_CELLS     = game_pkg::CAR_CELLS_DEF,
    parameter int PLAYER_FRAMES = game_pkg::PLAYER_FRAMES_DEF,
    parameter int CAR_FRAMES    = game_pkg::CAR_FRAMES_DEF,
    parameter int TILE_MARGIN   = game_pkg::TILE_MARGIN_DEF
) (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       btn_up,
    input  logic       btn_down,
    input  logic       btn_left,
    input  logic       btn_right,
    output logic [2:0] vga_r,
    output logic [2:0] vga_g,
    output logic [2:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs
);
    localparam int CW = vga_timing_pkg::CELL_W;
    localparam int PW = vga_timing_pkg::COORD_W;

    logic          h_sync_raw, v_sync_raw, active, frame_start;
    logic [CW-1:0] cell_col, cell_row;
    logic [PW-1:0] in_col, in_row;
    logic [CW-1:0] player_col, player_row;
    logic [CW-1:0] car_col [game_pkg::NUM_LANES];

    vga_timing #(
        .H_DISPLAY(H_DISPLAY), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_DISPLAY(V_DISPLAY), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .CELL_SIZE(CELL_SIZE)
    ) u_timing (.*);

    player_ctrl #(
        .H_DISPLAY(H_DISPLAY), .V_DISPLAY(V_DISPLAY), .CELL_SIZE(CELL_SIZE),
        .LANE_ROW0(LANE_ROW0), .CAR_CELLS(CAR_CELLS), .PLAYER_FRAMES(PLAYER_FRAMES)
    ) u_player (.*);

    traffic_lanes #(
        .H_DISPLAY(H_DISPLAY), .CELL_SIZE(CELL_SIZE), .CAR_FRAMES(CAR_FRAMES)
    ) u_lanes (.*);

    pixel_render #(
        .H_DISPLAY(H_DISPLAY), .CELL_SIZE(CELL_SIZE), .LANE_ROW0(LANE_ROW0),
        .CAR_CELLS(CAR_CELLS), .TILE_MARGIN(TILE_MARGIN)
    ) u_render (.*);

endmodule

// File: dv/tb_frogger.sv
`timescale 1ns/1ps

module tb_frogger;

    // 64x64 screen with 8x8 cells and short porches
    localparam int H_DISPLAY     = 64;
    localparam int H_FRONT       = 2;
    localparam int H_SYNC        = 4;
    localparam int H_BACK        = 2;
    localparam int V_DISPLAY     = 64;
    localparam int V_FRONT       = 1;
    localparam int V_SYNC        = 2;
    localparam int V_BACK        = 1;
    localparam int CELL_SIZE     = 8;
    localparam int LANE_ROW0     = 2;
    localparam int CAR_CELLS     = 2;
    localparam int PLAYER_FRAMES = 2;
    localparam int CAR_FRAMES    = 3;
    localparam int TILE_MARGIN   = 1;

    localparam int H_TOTAL      = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START     = H_DISPLAY + H_FRONT;
    localparam int VS_START     = V_DISPLAY + V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int COLS         = H_DISPLAY / CELL_SIZE;
    localparam int ROWS         = V_DISPLAY / CELL_SIZE;
    localparam int LANES        = 4;

    localparam int C_BLACK     = 0;
    localparam int C_WHITE     = 1;
    localparam int C_GREEN     = 2;
    localparam int C_RED       = 3;
    localparam int C_MODEL     = -1;  // Expected colour comes from the model
    localparam int PLAYER_CELL = -1;  // Probe wherever the model has the player

    logic       CLK       = 1'b0;
    logic       arst_n    = 1'b0;
    logic       btn_up    = 1'b0;
    logic       btn_down  = 1'b0;
    logic       btn_left  = 1'b0;
    logic       btn_right = 1'b0;
    logic [2:0] vga_r;
    logic [2:0] vga_g;
    logic [2:0] vga_b;
    logic       vga_hs;
    logic       vga_vs;

    // Copies of the DUT counters and the pixel now on the outputs
    int   h_cnt     = 0;
    int   v_cnt     = 0;
    int   out_h     = 0;
    int   out_v     = 0;
    logic out_valid = 1'b0;
    int   steps     = 0;
    int   m_col     = 0;
    int   m_row     = 0;
    int   m_cd      = 0;
    int   m_car [LANES];
    int   m_cnt [LANES];
    int   cycles    = 0;
    int   limit     = 0;

    string       t_name   [$];
    logic [3:0]  t_btn    [$];  // {up, down, left, right}
    int          t_frames [$];
    int          t_col    [$];
    int          t_row    [$];
    int          t_off    [$];
    int          t_exp    [$];
    logic        t_rnd    [$];
    logic [31:0] rnd_state = 32'h65a3f84e;

    frogger_top #(
        .H_DISPLAY(H_DISPLAY), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_DISPLAY(V_DISPLAY), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .CELL_SIZE(CELL_SIZE), .LANE_ROW0(LANE_ROW0), .CAR_CELLS(CAR_CELLS),
        .PLAYER_FRAMES(PLAYER_FRAMES), .CAR_FRAMES(CAR_FRAMES), .TILE_MARGIN(TILE_MARGIN)
    ) DUT (.*);

    initial begin
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [8:0] color_rgb(int c);
        case (c)
            C_WHITE: return 9'b111_111_111;
            C_GREEN: return 9'b000_111_000;
            C_RED:   return 9'b111_000_000;
            default: return 9'b000_000_000;
        endcase
    endfunction

    function automatic logic car_at(int col, int row);
        int lane;
        lane = row - LANE_ROW0;
        if (lane < 0 || lane >= LANES)
            return 1'b0;
        for (int k = 0; k < CAR_CELLS; k++) begin
            if ((m_car[lane] + k) % COLS == col)
                return 1'b1;  // Tail may wrap to column 0
        end
        return 1'b0;
    endfunction

    function automatic int model_color(int col, int row, int off);
        if (col == m_col && row == m_row)
            return C_GREEN;
        if (car_at(col, row))
            return C_RED;
        if (row >= LANE_ROW0 && row < LANE_ROW0 + LANES &&
            off >= TILE_MARGIN && off < CELL_SIZE - TILE_MARGIN)
            return C_WHITE;
        return C_BLACK;
    endfunction

    // One game frame of move, cars and then collision on the new positions
    task automatic model_step();
        int dc;
        int dr;
        dc = 0;
        dr = 0;
        if (btn_up)
            dr = -1;
        else if (btn_down)
            dr = 1;
        else if (btn_left)
            dc = -1;
        else if (btn_right)
            dc = 1;
        if (m_cd == 0 && (dc != 0 || dr != 0) && m_col + dc >= 0 && m_col + dc < COLS &&
            m_row + dr >= 0 && m_row + dr < ROWS) begin
            m_col = m_col + dc;
            m_row = m_row + dr;
            m_cd  = PLAYER_FRAMES;
        end else if (m_cd > 0) begin
            m_cd--;
        end
        for (int i = 0; i < LANES; i++) begin
            m_cnt[i]++;
            if (m_cnt[i] == CAR_FRAMES + i) begin
                m_cnt[i] = 0;
                m_car[i] = (m_car[i] + 1) % COLS;
            end
        end
        if (car_at(m_col, m_row)) begin
            m_col = COLS / 2;
            m_row = ROWS - 1;
        end
        steps++;
    endtask

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt     = 0;
            v_cnt     = 0;
            out_valid = 1'b0;
            m_col     = COLS / 2;
            m_row     = ROWS - 1;
            m_cd      = 0;
            for (int i = 0; i < LANES; i++) begin
                m_car[i] = 0;
                m_cnt[i] = 0;
            end
        end else begin
            if (h_cnt == 0 && v_cnt == 0)
                model_step();
            out_h     = h_cnt;
            out_v     = v_cnt;
            out_valid = 1'b1;
            if (h_cnt == H_TOTAL - 1) begin
                h_cnt = 0;
                v_cnt = (v_cnt == V_TOTAL - 1) ? 0 : v_cnt + 1;
            end else begin
                h_cnt++;
            end
        end
    end

    // Syncs and blanking on every pixel
    always @(negedge CLK) begin
        logic exp_hs;
        logic exp_vs;
        if (!out_valid) begin
            assert (vga_hs && vga_vs && {vga_r, vga_g, vga_b} == 9'd0) else begin
                $display("MISMATCH reset_idle: expected 1 1 000, actual %b %b %h",
                         vga_hs, vga_vs, {vga_r, vga_g, vga_b});
                $display("Finished with errors");
                $fatal(1, "reset state wrong");
            end
        end else begin
            exp_hs = !(out_h >= HS_START && out_h < HS_START + H_SYNC);
            exp_vs = !(out_v >= VS_START && out_v < VS_START + V_SYNC);
            assert (vga_hs == exp_hs && vga_vs == exp_vs) else begin
                $display("MISMATCH sync_timing at (%0d,%0d): expected %b%b, actual %b%b",
                         out_h, out_v, exp_hs, exp_vs, vga_hs, vga_vs);
                $display("Finished with errors");
                $fatal(1, "sync mismatch");
            end
            if (out_h >= H_DISPLAY || out_v >= V_DISPLAY) begin
                assert ({vga_r, vga_g, vga_b} == 9'd0) else begin
                    $display("MISMATCH blanking at (%0d,%0d): expected 000, actual %h",
                             out_h, out_v, {vga_r, vga_g, vga_b});
                    $display("Finished with errors");
                    $fatal(1, "porch not black");
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the table did not finish within %0d cycles", limit);
            $display("Finished with errors");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic add_entry(string name, logic [3:0] btn, int frames, int col, int row,
                             int off, int exp_c, logic rnd);
        t_name.push_back(name);
        t_btn.push_back(btn);
        t_frames.push_back(frames);
        t_col.push_back(col);
        t_row.push_back(row);
        t_off.push_back(off);
        t_exp.push_back(exp_c);
        t_rnd.push_back(rnd);
    endtask

    // Returns 1 ns after the next frame start edge
    task automatic wait_frame_start();
        int target;
        target = steps + 1;
        while (steps < target) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic drive_buttons(int k);
        if (t_rnd[k]) begin
            rnd_state = xorshift(rnd_state);
            {btn_up, btn_down, btn_left, btn_right} = rnd_state[3:0];
        end else begin
            {btn_up, btn_down, btn_left, btn_right} = t_btn[k];
        end
    endtask

    task automatic probe_cell(int k);
        int         col;
        int         row;
        int         exp_c;
        logic [8:0] got;
        col   = (t_col[k] == PLAYER_CELL) ? m_col : t_col[k];
        row   = (t_row[k] == PLAYER_CELL) ? m_row : t_row[k];
        exp_c = (t_exp[k] == C_MODEL) ? model_color(col, row, t_off[k]) : t_exp[k];
        while (!(out_h == col * CELL_SIZE + t_off[k] && out_v == row * CELL_SIZE + t_off[k]))
            @(negedge CLK);
        got = {vga_r, vga_g, vga_b};
        assert (got == color_rgb(exp_c)) else begin
            $display("MISMATCH %s: expected %h, actual %h", t_name[k], color_rgb(exp_c), got);
            $display("Finished with errors");
            $fatal(1, "pixel mismatch");
        end
    endtask

    initial begin
        int total;
        add_entry("start_cell",    4'b0000, 1,  4, 7, 4, C_GREEN, 1'b0);
        add_entry("lane_tile",     4'b0000, 0,  6, 5, 4, C_WHITE, 1'b0);
        add_entry("lane_margin",   4'b0000, 0,  6, 5, 0, C_BLACK, 1'b0);
        add_entry("verge_black",   4'b0000, 0,  1, 6, 4, C_BLACK, 1'b0);
        add_entry("down_refused",  4'b0100, 4,  4, 7, 4, C_GREEN, 1'b0);
        add_entry("up_one",        4'b1000, 3,  PLAYER_CELL, PLAYER_CELL, 4, C_MODEL, 1'b0);
        add_entry("start_vacated", 4'b1000, 0,  4, 7, 4, C_BLACK, 1'b0);
        add_entry("climb",         4'b1000, 12, PLAYER_CELL, PLAYER_CELL, 4, C_MODEL, 1'b0);
        add_entry("collided_cell", 4'b0000, 0,  4, 4, 4, C_MODEL, 1'b0);
        add_entry("car_lane0",     4'b0000, 0,  2, 2, 4, C_MODEL, 1'b0);
        add_entry("car_lane1",     4'b0000, 3,  0, 3, 4, C_MODEL, 1'b0);
        add_entry("car_wrap",      4'b0000, 7,  0, 5, 4, C_MODEL, 1'b0);
        add_entry("car_lane2",     4'b0000, 0,  0, 4, 4, C_MODEL, 1'b0);
        add_entry("random_hold",   4'b0000, 16, PLAYER_CELL, PLAYER_CELL, 4, C_MODEL, 1'b1);
        add_entry("start_after",   4'b0000, 0,  4, 7, 4, C_MODEL, 1'b0);
        total = 0;
        foreach (t_frames[k])
            total += t_frames[k] + 1;
        limit = (total + 2) * FRAME_CYCLES;

        repeat (5) @(posedge CLK);
        #1 arst_n = 1'b1;

        for (int k = 0; k < t_name.size(); k++) begin
            wait_frame_start();
            drive_buttons(k);
            for (int f = 0; f < t_frames[k]; f++) begin
                wait_frame_start();
                if (t_rnd[k])
                    drive_buttons(k);  // New random hold each frame
            end
            probe_cell(k);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: vlog.f
verilog/vga_timing_pkg.sv
verilog/game_pkg.sv
verilog/vga_timing.sv
verilog/player_ctrl.sv
verilog/traffic_lanes.sv
verilog/pixel_render.sv
verilog/frogger_top.sv
dv/tb_frogger.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the frogger testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_frogger \
    -Mdir obj_dir

./obj_dir/Vtb_frogger > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
